//--- mmuPkg.sv
package mmuPkg;

	////////////////////////////////////////
	// Region encoding
	////////////////////////////////////////
	typedef enum logic [3:0]
	{
		regionCart    = 4'd0,  // 0000 to 7FFF
		regionVram    = 4'd1,  // 8000 to 9FFF
		regionExt     = 4'd2,  // A000 to BFFF, no external RAM here
		regionWram    = 4'd3,  // C000 to FDFF with echo
		regionOam     = 4'd4,  // FE00 to FE9F
		regionUnused  = 4'd5,  // Holes and unmapped I/O
		regionJoypad  = 4'd6,  // FF00
		regionLcdRegs = 4'd7,  // FF40 to FF4B
		regionHram    = 4'd8,  // FF80 to FFFE
		regionIe      = 4'd9,  // FFFF
		regionBlocked = 4'd10  // Video memory owned by the video unit
	} mmuRegionE;

	// Decoder result, one strobe per writable target
	typedef struct packed
	{
		mmuRegionE region;
		logic      vramWe;
		logic      oamWe;
		logic      wramWe;
		logic      hramWe;
		logic      ieWe;
		logic      lcdRegWe;    // Whole FF40 to FF4F block
		logic      gpuOwnsVmem;
	} mmuDecodeT;

	// LCD registers in address order, lcdc lands in the top byte
	typedef struct packed
	{
		logic [7:0] lcdc;
		logic [7:0] stat;
		logic [7:0] scy;
		logic [7:0] scx;
		logic [7:0] ly;
		logic [7:0] lyc;
		logic [7:0] dma;
		logic [7:0] bgp;
		logic [7:0] obp0;
		logic [7:0] obp1;
		logic [7:0] wy;
		logic [7:0] wx;
	} gpuRegsT;

	// Bytes the store hands to the read mux
	typedef struct packed
	{
		logic [7:0] cpuVram;
		logic [7:0] cpuOam;
		logic [7:0] wram;
		logic [7:0] hram;
		logic [7:0] ie;
	} storeReadT;

	////////////////////////////////////////
	// Memory sizes in bytes
	////////////////////////////////////////
	localparam int vramBytes = 8192;
	localparam int oamBytes  = 160;
	localparam int wramBytes = 8192;
	localparam int hramBytes = 127;

	// Address map, each entry is the first address of its region
	localparam logic [15:0] vramBase    = 16'h8000;
	localparam logic [15:0] extBase     = 16'hA000;
	localparam logic [15:0] wramBase    = 16'hC000;
	localparam logic [15:0] oamBase     = 16'hFE00;
	localparam logic [15:0] unusedBase  = 16'hFEA0;
	localparam logic [15:0] joypadAddr  = 16'hFF00;
	localparam logic [15:0] lcdRegBase  = 16'hFF40;
	localparam logic [15:0] lcdRegLimit = 16'hFF4C; // First address past wx
	localparam logic [15:0] hramBase    = 16'hFF80;
	localparam logic [15:0] ieAddr      = 16'hFFFF;

endpackage

//--- mmuRam.sv
module mmuRam
#(
	parameter int depth     = 256,
	parameter int addrWidth = 8
)
(
	input  logic                 iEnable,
	input  logic                 we,
	input  logic [addrWidth-1:0] wAddr,
	input  logic [addrWidth-1:0] rAddr,
	input  logic [7:0]           wData,
	output logic [7:0]           rData
);

	// Depth may be short of the full address space
	localparam logic [addrWidth:0] depthLimit = (addrWidth + 1)'(depth);

	logic [7:0] mem [depth];
	logic       wInRange;
	logic       rInRange;

	assign wInRange = {1'b0, wAddr} < depthLimit;
	assign rInRange = {1'b0, rAddr} < depthLimit;

	// Synchronous write, out of range writes are dropped
	always_ff @(posedge iEnable)
	begin
		if (we && wInRange)
			mem[wAddr] <= wData;
	end

	// Combinational read
	assign rData = rInRange ? mem[rAddr] : 8'h00; // Past the end reads 00

endmodule

//--- mmuDecode.sv
module mmuDecode
(
	input  logic [15:0]       cpuAddr,
	input  logic              cpuWe,
	input  logic              lcdOn,        // lcdc bit 7
	input  logic              statModeHigh, // STAT mode bit 1
	output mmuPkg::mmuDecodeT decodeBus
);

	mmuPkg::mmuRegionE rawRegion; // Region before the owner rule
	mmuPkg::mmuRegionE region;
	logic              gpuOwnsVmem;

	////////////////////////////////////////
	// Address classification
	////////////////////////////////////////
	always_comb
	begin
		// Walk the map from the bottom up
		if (cpuAddr < mmuPkg::vramBase)
			rawRegion = mmuPkg::regionCart;
		else if (cpuAddr < mmuPkg::extBase)
			rawRegion = mmuPkg::regionVram;
		else if (cpuAddr < mmuPkg::wramBase)
			rawRegion = mmuPkg::regionExt;
		else if (cpuAddr < mmuPkg::oamBase)
			rawRegion = mmuPkg::regionWram;   // Echo folds in here too
		else if (cpuAddr < mmuPkg::unusedBase)
			rawRegion = mmuPkg::regionOam;
		else if (cpuAddr < mmuPkg::joypadAddr)
			rawRegion = mmuPkg::regionUnused; // FEA0 to FEFF
		else if (cpuAddr == mmuPkg::joypadAddr)
			rawRegion = mmuPkg::regionJoypad;
		else if (cpuAddr >= mmuPkg::lcdRegBase && cpuAddr < mmuPkg::lcdRegLimit)
			rawRegion = mmuPkg::regionLcdRegs;
		else if (cpuAddr < mmuPkg::hramBase)
			rawRegion = mmuPkg::regionUnused; // Sound, timers and the rest of I/O
		else if (cpuAddr < mmuPkg::ieAddr)
			rawRegion = mmuPkg::regionHram;
		else
			rawRegion = mmuPkg::regionIe;
	end

	// Video unit holds VRAM and OAM while LCD is on and mode bit 1 is set
	assign gpuOwnsVmem = lcdOn & statModeHigh;

	always_comb
	begin
		region = rawRegion;
		if (gpuOwnsVmem &&
			(rawRegion == mmuPkg::regionVram || rawRegion == mmuPkg::regionOam))
			region = mmuPkg::regionBlocked; // CPU locked out
	end

	////////////////////////////////////////
	// Write strobes
	////////////////////////////////////////
	always_comb
	begin
		decodeBus             = '0;
		decodeBus.region      = region;
		decodeBus.gpuOwnsVmem = gpuOwnsVmem;
		// At most one memory strobe, blocked and read-only regions get none
		case (region)
			mmuPkg::regionVram: decodeBus.vramWe = cpuWe;
			mmuPkg::regionOam:  decodeBus.oamWe  = cpuWe;
			mmuPkg::regionWram: decodeBus.wramWe = cpuWe;
			mmuPkg::regionHram: decodeBus.hramWe = cpuWe;
			mmuPkg::regionIe:   decodeBus.ieWe   = cpuWe;
			default:
			begin
				// Cart, ext, unused, joypad, LCD regs and blocked write nothing here
			end
		endcase
		// Video unit sees every write into the FF4x block
		decodeBus.lcdRegWe = cpuWe && (cpuAddr[15:4] == mmuPkg::lcdRegBase[15:4]);
	end

endmodule

//--- mmuStore.sv
module mmuStore
#(
	parameter int vramDepth = 8192,
	parameter int oamDepth  = 160,
	parameter int wramDepth = 8192,
	parameter int hramDepth = 127
)
(
	input  logic              iEnable,
	input  logic              rstN,
	input  logic [15:0]       cpuAddr,
	input  logic [7:0]        cpuWData,
	input  logic [15:0]       gpuAddr,
	input  mmuPkg::mmuDecodeT decodeBus,
	output mmuPkg::storeReadT storeBus,
	output logic [7:0]        gpuVramByte,
	output logic [7:0]        gpuOamByte
);

	// Address widths follow the depths
	localparam int vramAw = $clog2(vramDepth);
	localparam int oamAw  = $clog2(oamDepth);
	localparam int wramAw = $clog2(wramDepth);
	localparam int hramAw = $clog2(hramDepth);

	logic [15:0] vmemAddr;  // Shared VRAM and OAM read address
	logic [7:0]  vramByte;
	logic [7:0]  oamByte;
	logic [7:0]  wramByte;
	logic [7:0]  hramByte;
	logic [7:0]  ieReg;     // Interrupt enable at FFFF

	// Owner picks the read address
	assign vmemAddr = decodeBus.gpuOwnsVmem ? gpuAddr : cpuAddr;

	////////////////////////////////////////
	// Memories
	////////////////////////////////////////
	mmuRam #(.depth(vramDepth), .addrWidth(vramAw)) vramMem
	(
		.iEnable (iEnable),
		.we      (decodeBus.vramWe),
		.wAddr   (cpuAddr[vramAw-1:0]),
		.rAddr   (vmemAddr[vramAw-1:0]),
		.wData   (cpuWData),
		.rData   (vramByte)
	);

	mmuRam #(.depth(oamDepth), .addrWidth(oamAw)) oamMem
	(
		.iEnable (iEnable),
		.we      (decodeBus.oamWe),       // Own strobe, no longer tied to VRAM
		.wAddr   (cpuAddr[oamAw-1:0]),
		.rAddr   (vmemAddr[oamAw-1:0]),
		.wData   (cpuWData),
		.rData   (oamByte)
	);

	// Thirteen low bits fold E000 to FDFF onto C000 to DDFF
	mmuRam #(.depth(wramDepth), .addrWidth(wramAw)) wramMem
	(
		.iEnable (iEnable),
		.we      (decodeBus.wramWe),
		.wAddr   (cpuAddr[wramAw-1:0]),
		.rAddr   (cpuAddr[wramAw-1:0]),
		.wData   (cpuWData),
		.rData   (wramByte)
	);

	mmuRam #(.depth(hramDepth), .addrWidth(hramAw)) hramMem
	(
		.iEnable (iEnable),
		.we      (decodeBus.hramWe),
		.wAddr   (cpuAddr[hramAw-1:0]),  // FF80 maps to entry 0
		.rAddr   (cpuAddr[hramAw-1:0]),
		.wData   (cpuWData),
		.rData   (hramByte)
	);

	////////////////////////////////////////
	// Interrupt enable register
	////////////////////////////////////////
	always_ff @(posedge iEnable or negedge rstN)
	begin
		if (!rstN)
			ieReg <= 8'h00;
		else if (decodeBus.ieWe)
			ieReg <= cpuWData;
	end

	// One read port per video memory serves both sides
	assign storeBus.cpuVram = vramByte;
	assign storeBus.cpuOam  = oamByte;
	assign storeBus.wram    = wramByte;
	assign storeBus.hram    = hramByte;
	assign storeBus.ie      = ieReg;
	assign gpuVramByte      = vramByte;
	assign gpuOamByte       = oamByte;

endmodule

//--- mmuReadMux.sv
module mmuReadMux
(
	input  logic [3:0]        cpuAddr,  // Low nibble picks the LCD register
	input  logic [15:8]       gpuAddr,  // Upper byte picks VRAM or OAM
	input  mmuPkg::mmuDecodeT decodeBus,
	input  mmuPkg::storeReadT storeBus,
	input  logic [7:0]        gpuVramByte,
	input  logic [7:0]        gpuOamByte,
	input  mmuPkg::gpuRegsT   gpuRegs,
	input  logic [7:0]        buttons,
	input  logic [7:0]        cartData,
	output logic [7:0]        cpuRData,
	output logic [7:0]        gpuVmemData
);

	logic [7:0] lcdRegByte;

	////////////////////////////////////////
	// LCD register select
	////////////////////////////////////////
	always_comb
	begin
		case (cpuAddr)
			4'h0:    lcdRegByte = gpuRegs.lcdc;
			4'h1:    lcdRegByte = gpuRegs.stat;
			4'h2:    lcdRegByte = gpuRegs.scy;
			4'h3:    lcdRegByte = gpuRegs.scx;
			4'h4:    lcdRegByte = gpuRegs.ly;
			4'h5:    lcdRegByte = gpuRegs.lyc;
			4'h6:    lcdRegByte = gpuRegs.dma;
			4'h7:    lcdRegByte = gpuRegs.bgp;
			4'h8:    lcdRegByte = gpuRegs.obp0;
			4'h9:    lcdRegByte = gpuRegs.obp1;
			4'hA:    lcdRegByte = gpuRegs.wy;
			4'hB:    lcdRegByte = gpuRegs.wx;
			default: lcdRegByte = 8'h00; // FF4C to FF4F decode as unused anyway
		endcase
	end

	////////////////////////////////////////
	// CPU read byte by region
	////////////////////////////////////////
	always_comb
	begin
		case (decodeBus.region)
			mmuPkg::regionCart:    cpuRData = cartData;
			mmuPkg::regionVram:    cpuRData = storeBus.cpuVram;
			mmuPkg::regionExt:     cpuRData = 8'h00;  // No cartridge RAM
			mmuPkg::regionWram:    cpuRData = storeBus.wram;
			mmuPkg::regionOam:     cpuRData = storeBus.cpuOam;
			mmuPkg::regionUnused:  cpuRData = 8'h00;
			mmuPkg::regionJoypad:  cpuRData = buttons;
			mmuPkg::regionLcdRegs: cpuRData = lcdRegByte;
			mmuPkg::regionHram:    cpuRData = storeBus.hram;
			mmuPkg::regionIe:      cpuRData = storeBus.ie;
			mmuPkg::regionBlocked: cpuRData = 8'hFF;  // Video unit owns the bus
			default:               cpuRData = 8'h00;
		endcase
	end

	// Video unit read, OAM lives in page FE
	assign gpuVmemData = (gpuAddr == mmuPkg::oamBase[15:8]) ? gpuOamByte : gpuVramByte;

endmodule

//--- mmuTop.sv
module mmuTop
#(
	parameter int vramDepth = mmuPkg::vramBytes,
	parameter int oamDepth  = mmuPkg::oamBytes,
	parameter int wramDepth = mmuPkg::wramBytes,
	parameter int hramDepth = mmuPkg::hramBytes
)
(
	input  logic            iEnable,
	input  logic            rstN,
	// CPU side
	input  logic [15:0]     cpuAddr,
	input  logic            cpuWe,
	input  logic [7:0]      cpuWData,
	output logic [7:0]      cpuRData,
	// Video unit side
	input  logic [15:0]     gpuAddr,
	output logic [7:0]      gpuVmemData,
	input  mmuPkg::gpuRegsT gpuRegs,
	output logic            gpuRegWe,
	output logic [3:0]      gpuRegSelect,
	output logic [7:0]      gpuRegData,
	// Joypad and cartridge
	input  logic [7:0]      buttons,
	input  logic [7:0]      cartData
);

	mmuPkg::mmuDecodeT decodeBus;
	mmuPkg::storeReadT storeBus;
	logic [7:0]        gpuVramByte;
	logic [7:0]        gpuOamByte;

	////////////////////////////////////////
	// Decode, store, read
	////////////////////////////////////////
	mmuDecode decode
	(
		.cpuAddr      (cpuAddr),
		.cpuWe        (cpuWe),
		.lcdOn        (gpuRegs.lcdc[7]),
		.statModeHigh (gpuRegs.stat[1]),
		.decodeBus    (decodeBus)
	);

	mmuStore #(
		.vramDepth (vramDepth),
		.oamDepth  (oamDepth),
		.wramDepth (wramDepth),
		.hramDepth (hramDepth)
	) execute
	(
		.iEnable     (iEnable),
		.rstN        (rstN),
		.cpuAddr     (cpuAddr),
		.cpuWData    (cpuWData),
		.gpuAddr     (gpuAddr),
		.decodeBus   (decodeBus),
		.storeBus    (storeBus),
		.gpuVramByte (gpuVramByte),
		.gpuOamByte  (gpuOamByte)
	);

	mmuReadMux result
	(
		.cpuAddr     (cpuAddr[3:0]),
		.gpuAddr     (gpuAddr[15:8]),
		.decodeBus   (decodeBus),
		.storeBus    (storeBus),
		.gpuVramByte (gpuVramByte),
		.gpuOamByte  (gpuOamByte),
		.gpuRegs     (gpuRegs),
		.buttons     (buttons),
		.cartData    (cartData),
		.cpuRData    (cpuRData),
		.gpuVmemData (gpuVmemData)
	);

	// LCD register write port, same cycle as the CPU write
	assign gpuRegWe     = decodeBus.lcdRegWe;
	assign gpuRegSelect = cpuAddr[3:0];  // Register index within FF4x
	assign gpuRegData   = cpuWData;

endmodule

//--- tbMmuChecker.sv
module tbMmuChecker
(
	input  logic            iEnable,
	input  logic            rstN,
	input  logic [15:0]     cpuAddr,
	input  logic            cpuWe,
	input  logic [7:0]      cpuWData,
	input  logic [7:0]      cpuRData,
	input  logic [15:0]     gpuAddr,
	input  logic [7:0]      gpuVmemData,
	input  mmuPkg::gpuRegsT gpuRegs,
	input  logic            gpuRegWe,
	input  logic [3:0]      gpuRegSelect,
	input  logic [7:0]      gpuRegData,
	input  logic [7:0]      buttons,
	input  logic [7:0]      cartData,
	input  logic            finished,   // Rises once when stimulus is over
	output int              errorCount
);
	timeunit 1ns;
	timeprecision 100ps;

	// Shadow memories with a known bit per byte since the RAMs start undefined
	logic [7:0] vramShadow [mmuPkg::vramBytes];
	bit         vramKnown  [mmuPkg::vramBytes];
	logic [7:0] oamShadow  [mmuPkg::oamBytes];
	bit         oamKnown   [mmuPkg::oamBytes];
	logic [7:0] wramShadow [mmuPkg::wramBytes];
	bit         wramKnown  [mmuPkg::wramBytes];
	logic [7:0] hramShadow [mmuPkg::hramBytes];
	bit         hramKnown  [mmuPkg::hramBytes];
	logic [7:0] ieShadow = 8'h00;
	int         mismatches = 0;
	int         checkCount = 0;

	assign errorCount = mismatches;

	// Video unit owns VRAM and OAM with LCD on and mode bit 1 set
	function automatic logic ownedByGpu(mmuPkg::gpuRegsT regs);
		return regs.lcdc[7] & regs.stat[1];
	endfunction

	////////////////////////////////////////
	// Reference model where bit 8 flags a known byte
	////////////////////////////////////////
	function automatic logic [8:0] expectCpuRead(logic [15:0] addr, mmuPkg::gpuRegsT regs,
		logic [7:0] pad, logic [7:0] cart);
		int  wramIdx;
		logic blocked;
		wramIdx = (addr - 16'hC000) % mmuPkg::wramBytes;  // Echo folds onto C000
		blocked = ownedByGpu(regs);
		if (addr < 16'h8000)
			return {1'b1, cart};
		else if (addr < 16'hA000)
			return blocked ? 9'h1FF : {vramKnown[addr - 16'h8000], vramShadow[addr - 16'h8000]};
		else if (addr < 16'hC000)
			return 9'h100;                                // No cartridge RAM
		else if (addr < 16'hFE00)
			return {wramKnown[wramIdx], wramShadow[wramIdx]};
		else if (addr < 16'hFEA0)
			return blocked ? 9'h1FF : {oamKnown[addr - 16'hFE00], oamShadow[addr - 16'hFE00]};
		else if (addr == 16'hFF00)
			return {1'b1, pad};
		else if (addr >= 16'hFF40 && addr < 16'hFF4C)
			return {1'b1, regs[(11 - addr[3:0]) * 8 +: 8]};  // lcdc sits in the top byte
		else if (addr >= 16'hFF80 && addr < 16'hFFFF)
			return {hramKnown[addr - 16'hFF80], hramShadow[addr - 16'hFF80]};
		else if (addr == 16'hFFFF)
			return {1'b1, ieShadow};
		return 9'h100;                                    // Holes, sound and timers
	endfunction

	function automatic logic [8:0] expectGpuRead(logic [15:0] gAddr, logic [15:0] cAddr,
		mmuPkg::gpuRegsT regs);
		logic [15:0] port;
		port = ownedByGpu(regs) ? gAddr : cAddr;          // Shared read port follows the owner
		if (gAddr[15:8] == 8'hFE)
			return (port[7:0] < mmuPkg::oamBytes) ?
				{oamKnown[port[7:0]], oamShadow[port[7:0]]} : 9'h100;
		return {vramKnown[port[12:0]], vramShadow[port[12:0]]};
	endfunction

	// Apply one CPU write to the shadows
	task automatic recordWrite(logic [15:0] addr, logic [7:0] data, logic blocked);
		int wramIdx;
		wramIdx = (addr - 16'hC000) % mmuPkg::wramBytes;
		if (addr >= 16'h8000 && addr < 16'hA000 && !blocked)
		begin
			vramShadow[addr - 16'h8000] = data;
			vramKnown[addr - 16'h8000]  = 1'b1;
		end
		else if (addr >= 16'hC000 && addr < 16'hFE00)
		begin
			wramShadow[wramIdx] = data;
			wramKnown[wramIdx]  = 1'b1;
		end
		else if (addr >= 16'hFE00 && addr < 16'hFEA0 && !blocked)
		begin
			oamShadow[addr - 16'hFE00] = data;
			oamKnown[addr - 16'hFE00]  = 1'b1;
		end
		else if (addr >= 16'hFF80 && addr < 16'hFFFF)
		begin
			hramShadow[addr - 16'hFF80] = data;
			hramKnown[addr - 16'hFF80]  = 1'b1;
		end
		else if (addr == 16'hFFFF)
			ieShadow = data;
	endtask

	task automatic compareValue(string name, logic [8:0] expected, logic [7:0] actual);
		if (expected[8])                                  // Undefined bytes are skipped
		begin
			checkCount++;
			if (actual !== expected[7:0])
			begin
				mismatches++;
				$display("MISMATCH %s expected %02h actual %02h at %0t",
					name, expected[7:0], actual, $time);
			end
		end
	endtask

	////////////////////////////////////////
	// Compare on the falling edge
	////////////////////////////////////////
	always @(negedge iEnable)
	begin
		if (!rstN)
			ieShadow = 8'h00;                             // IE clears in reset
		else
		begin
			compareValue("cpuRData", expectCpuRead(cpuAddr, gpuRegs, buttons, cartData),
				cpuRData);
			compareValue("gpuVmemData", expectGpuRead(gpuAddr, cpuAddr, gpuRegs), gpuVmemData);
			compareValue("gpuRegWe",
				{8'h80, (cpuWe && cpuAddr >= 16'hFF40 && cpuAddr <= 16'hFF4F)},
				{7'h0, gpuRegWe});
			if (cpuWe)
			begin
				compareValue("gpuRegSelect", {5'h10, cpuAddr[3:0]}, {4'h0, gpuRegSelect});
				compareValue("gpuRegData", {1'b1, cpuWData}, gpuRegData);
				recordWrite(cpuAddr, cpuWData, ownedByGpu(gpuRegs)); // Lands at the next edge
			end
		end
	end

	always @(posedge finished)
		$display("Checker summary: %0d checks, %0d mismatches", checkCount, mismatches);

endmodule

//--- tbMmu.sv
module tbMmu;
	timeunit 1ns;
	timeprecision 100ps;

	// Phase lengths in cycles
	localparam int resetCycles = 4;
	localparam int ieCycles    = 3;
	localparam int fillCycles  = 256 + mmuPkg::oamBytes;  // VRAM 8000 to 80FF plus all of OAM
	localparam int memTrials   = 400;                     // Each trial writes then reads
	localparam int holeReads   = 80;
	localparam int ownedTrials = 100;
	localparam int readbacks   = 100;
	localparam int regWrites   = 32;
	localparam int inputReads  = 100;
	localparam int totalCycles = resetCycles + ieCycles + fillCycles + 2 * memTrials
		+ holeReads + 2 * ownedTrials + readbacks + regWrites + inputReads + 2;

	logic            iEnable;
	logic            rstN;
	logic [15:0]     cpuAddr;
	logic            cpuWe;
	logic [7:0]      cpuWData;
	logic [7:0]      cpuRData;
	logic [15:0]     gpuAddr;
	logic [7:0]      gpuVmemData;
	mmuPkg::gpuRegsT gpuRegs;
	logic            gpuRegWe;
	logic [3:0]      gpuRegSelect;
	logic [7:0]      gpuRegData;
	logic [7:0]      buttons;
	logic [7:0]      cartData;
	logic            finished;
	int              errorCount;

	mmuTop DUT
	(
		.iEnable      (iEnable),
		.rstN         (rstN),
		.cpuAddr      (cpuAddr),
		.cpuWe        (cpuWe),
		.cpuWData     (cpuWData),
		.cpuRData     (cpuRData),
		.gpuAddr      (gpuAddr),
		.gpuVmemData  (gpuVmemData),
		.gpuRegs      (gpuRegs),
		.gpuRegWe     (gpuRegWe),
		.gpuRegSelect (gpuRegSelect),
		.gpuRegData   (gpuRegData),
		.buttons      (buttons),
		.cartData     (cartData)
	);

	tbMmuChecker scoreboard
	(
		.iEnable      (iEnable),
		.rstN         (rstN),
		.cpuAddr      (cpuAddr),
		.cpuWe        (cpuWe),
		.cpuWData     (cpuWData),
		.cpuRData     (cpuRData),
		.gpuAddr      (gpuAddr),
		.gpuVmemData  (gpuVmemData),
		.gpuRegs      (gpuRegs),
		.gpuRegWe     (gpuRegWe),
		.gpuRegSelect (gpuRegSelect),
		.gpuRegData   (gpuRegData),
		.buttons      (buttons),
		.cartData     (cartData),
		.finished     (finished),
		.errorCount   (errorCount)
	);

	initial
	begin
		iEnable = 1'b0;
		forever #5 iEnable = ~iEnable;  // 10 ns period
	end

	// Watchdog sized from the phase lengths
	initial
	begin
		#((totalCycles + 100) * 10);
		$display("Timeout: stimulus did not finish within %0d cycles", totalCycles + 100);
		$display("Simulation FAILED");
		$finish;
	end

	////////////////////////////////////////
	// Stimulus helpers
	////////////////////////////////////////
	// One bus cycle driven just after the rising edge
	task automatic driveCycle(input logic [15:0] addr, input logic we, input logic [7:0] data);
		@(posedge iEnable);
		#1;
		cpuAddr  = addr;
		cpuWe    = we;
		cpuWData = data;
		buttons  = 8'($urandom);
		cartData = 8'($urandom);
		// Video unit looks at filled VRAM or anywhere in page FE
		gpuAddr  = ($urandom % 2) ? {8'hFE, 8'($urandom)} : 16'h8000 + 16'($urandom % 256);
	endtask

	function automatic logic [15:0] pickMemAddr(int kind);
		case (kind)
			0:       return 16'h8000 + 16'($urandom % 8192);
			1:       return 16'hFE00 + 16'($urandom % 160);
			2:       return 16'hC000 + 16'($urandom % 16'h3E00); // Work RAM and echo
			default: return 16'hFF80 + 16'($urandom % 127);
		endcase
	endfunction

	initial
	begin
		logic [15:0] addr;
		void'($urandom(32'hd06a_682b));
		rstN     = 1'b0;
		cpuAddr  = 16'h0000;
		cpuWe    = 1'b0;
		cpuWData = 8'h00;
		gpuAddr  = 16'h8000;
		gpuRegs  = '0;
		buttons  = 8'h00;
		cartData = 8'h00;
		finished = 1'b0;
		repeat (resetCycles) @(posedge iEnable);
		#1 rstN = 1'b1;

		// IE reads 00 out of reset and then takes a write
		driveCycle(16'hFFFF, 1'b0, 8'h00);
		driveCycle(16'hFFFF, 1'b1, 8'($urandom));
		driveCycle(16'hFFFF, 1'b0, 8'h00);

		// Known contents where the video unit will read
		for (int i = 0; i < 256; i++)
			driveCycle(16'h8000 + 16'(i), 1'b1, 8'($urandom));
		for (int i = 0; i < mmuPkg::oamBytes; i++)
			driveCycle(16'hFE00 + 16'(i), 1'b1, 8'($urandom));

		for (int i = 0; i < memTrials; i++)
		begin
			addr = pickMemAddr(i % 4);
			driveCycle(addr, 1'b1, 8'($urandom));
			driveCycle(addr, 1'b0, 8'h00);
		end

		// Holes read 00
		for (int i = 0; i < holeReads; i++)
		begin
			case (i % 4)
				0:       addr = 16'hFEA0 + 16'($urandom % 96);
				1:       addr = 16'hA000 + 16'($urandom % 8192);
				2:       addr = 16'hFF01 + 16'($urandom % 63);
				default: addr = 16'hFF4C + 16'($urandom % 52);
			endcase
			driveCycle(addr, 1'b0, 8'h00);
		end

		////////////////////////////////////////
		// Video unit owns VRAM and OAM
		////////////////////////////////////////
		gpuRegs.lcdc = 8'h80 | 8'($urandom);
		gpuRegs.stat = 8'h02 | 8'($urandom);
		for (int i = 0; i < ownedTrials; i++)
		begin
			// Stay inside the filled window so a leaked write shows up in later reads
			addr = (i % 2) ? 16'hFE00 + 16'($urandom % 160) : 16'h8000 + 16'($urandom % 256);
			driveCycle(addr, 1'b1, 8'($urandom));  // Dropped
			driveCycle(addr, 1'b0, 8'h00);         // Reads FF
		end
		gpuRegs = '0;
		for (int i = 0; i < readbacks; i++)
		begin
			addr = (i % 2) ? 16'hFE00 + 16'($urandom % 160) : 16'h8000 + 16'($urandom % 256);
			driveCycle(addr, 1'b0, 8'h00);
		end

		// LCD register write port and then writes elsewhere
		for (int n = 0; n < 16; n++)
			driveCycle(16'hFF40 + 16'(n), 1'b1, 8'($urandom));
		for (int i = 0; i < regWrites - 16; i++)
			driveCycle(pickMemAddr(i % 4), 1'b1, 8'($urandom));

		// Register, joypad and cartridge reads under changing inputs
		for (int i = 0; i < inputReads; i++)
		begin
			case (i % 3)
				0:       addr = 16'hFF40 + 16'($urandom % 12);
				1:       addr = 16'hFF00;
				default: addr = 16'($urandom % 32768);
			endcase
			driveCycle(addr, 1'b0, 8'h00);
			gpuRegs = mmuPkg::gpuRegsT'({$urandom, $urandom, $urandom});
		end

		repeat (2) driveCycle(16'h0000, 1'b0, 8'h00);
		finished = 1'b1;
		#1;
		if (errorCount == 0)
			$display("Simulation PASSED");
		else
			$display("Simulation FAILED");
		$finish;
	end

endmodule

//--- list.f
mmuPkg.sv
mmuRam.sv
mmuDecode.sv
mmuStore.sv
mmuReadMux.sv
mmuTop.sv
tbMmuChecker.sv
tbMmu.sv

//--- Bender.yml
package:
  name: mmu

sources:
  - mmuPkg.sv
  - mmuRam.sv
  - mmuDecode.sv
  - mmuStore.sv
  - mmuReadMux.sv
  - mmuTop.sv
  - target: test
    files:
      - tbMmuChecker.sv
      - tbMmu.sv
